// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - design/memBusPkg.sv
  - design/mmioUnit.sv
  - design/wishboneManager.sv
  - design/sramWishbone.sv
  - design/memSubsystemTop.sv
  - target: test
    files:
      - tests/memSubsystem_checker.sv
      - tests/memSubsystemTb.sv

// File: build.f
design/memBusPkg.sv
design/mmioUnit.sv
design/wishboneManager.sv
design/sramWishbone.sv
design/memSubsystemTop.sv
tests/memSubsystem_checker.sv
tests/memSubsystemTb.sv

// File: design/memBusPkg.sv
package memBusPkg;

    // bus widths
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BYTE_LANES = DATA_W / 8;

    // byte address as seen by the core
    typedef logic [ADDR_W-1:0]     addrT;
    // one data word
    typedef logic [DATA_W-1:0]     dataT;
    // one enable bit per byte lane
    typedef logic [BYTE_LANES-1:0] byteEnT;

    // core access code, read = 10, write = 01, idle = 00
    typedef enum logic [1:0] {
        accessIdle  = 2'b00,
        accessWrite = 2'b01,
        accessRead  = 2'b10
    } accessE;

    // request presented by the core, held while busy is high
    typedef struct packed {
        accessE access;
        addrT   addr;
        dataT   wdata;
        byteEnT byteEn;
    } coreReqT;

    // request handed from the I/O unit to the bus manager
    typedef struct packed {
        logic   we;
        addrT   addr;
        dataT   wdata;
        byteEnT sel;
    } busReqT;

    // classic Wishbone, manager to slave
    typedef struct packed {
        logic   cyc;
        logic   stb;
        logic   we;
        addrT   adr;
        dataT   dat;
        byteEnT sel;
    } wbMasterT;

    // classic Wishbone, slave to manager
    typedef struct packed {
        logic ack;
        dataT dat;
    } wbSlaveT;

    // display region, an address hits it when (addr & mask) == base
    localparam addrT DISPLAY_BASE = 32'hF000_0000;
    localparam addrT DISPLAY_MASK = 32'hFFFF_0000;

endpackage

// File: design/memSubsystemTop.sv
module memSubsystemTop import memBusPkg::*; #(
    parameter int SRAM_WORDS  = 256,
    parameter int WAIT_STATES = 2
) (
    input  logic    clk,
    input  logic    rstN_i,
    input  coreReqT coreReq_i,
    output logic    busy_o,
    output logic    done_o,
    output dataT    rdata_o,
    output logic    accessError_o,
    output logic    dispWrite_o,
    output addrT    dispAddr_o,
    output dataT    dispData_o
);

    // I/O unit to bus manager
    busReqT   busReq;
    logic     busStart;
    logic     busDone;
    dataT     busRdata;

    // Wishbone between manager and SRAM
    wbMasterT wbM;
    wbSlaveT  wbS;

    mmioUnit mmio (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .coreReq_i     (coreReq_i),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .rdata_o       (rdata_o),
        .accessError_o (accessError_o),
        .dispWrite_o   (dispWrite_o),
        .dispAddr_o    (dispAddr_o),
        .dispData_o    (dispData_o),
        .busReq_o      (busReq),
        .busStart_o    (busStart),
        .busDone_i     (busDone),
        .busRdata_i    (busRdata)
    );

    wishboneManager wbManager (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .busReq_i   (busReq),
        .busStart_i (busStart),
        .busDone_o  (busDone),
        .busRdata_o (busRdata),
        .wbM_o      (wbM),
        .wbS_i      (wbS)
    );

    sramWishbone #(
        .SRAM_WORDS  (SRAM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) sram (
        .clk    (clk),
        .rstN_i (rstN_i),
        .wbM_i  (wbM),
        .wbS_o  (wbS)
    );

endmodule

// File: design/mmioUnit.sv
module mmioUnit import memBusPkg::*; (
    input  logic    clk,
    input  logic    rstN_i,
    input  coreReqT coreReq_i,
    output logic    busy_o,
    output logic    done_o,
    output dataT    rdata_o,
    output logic    accessError_o,
    output logic    dispWrite_o,
    output addrT    dispAddr_o,
    output dataT    dispData_o,
    output busReqT  busReq_o,
    output logic    busStart_o,
    input  logic    busDone_i,
    input  dataT    busRdata_i
);

    typedef enum logic [1:0] {
        idle,
        waitBus,
        respond
    } stateE;

    stateE state;
    logic  isWrite;
    logic  isRead;
    logic  inDisplay;
    logic  accept;
    logic  errorQ;
    logic  dispWriteQ;

    assign isWrite   = coreReq_i.access == accessWrite;
    assign isRead    = coreReq_i.access == accessRead;
    assign inDisplay = (coreReq_i.addr & DISPLAY_MASK) == DISPLAY_BASE;

    // busy only while a bus transaction is outstanding
    assign busy_o = state == waitBus;
    assign accept = (isWrite || isRead) && !busy_o;

    // respond lasts one cycle, it is the done pulse
    assign done_o        = state == respond;
    assign accessError_o = (state == respond) && errorQ;
    assign dispWrite_o   = (state == respond) && dispWriteQ;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            state      <= idle;
            busStart_o <= 1'b0;
            errorQ     <= 1'b0;
            dispWriteQ <= 1'b0;
        end else begin
            busStart_o <= 1'b0;
            case (state)
                idle, respond: begin
                    if (accept && inDisplay) begin
                        // display is write only, a read is an access error
                        state      <= respond;
                        errorQ     <= isRead;
                        dispWriteQ <= isWrite;
                    end else if (accept) begin
                        state      <= waitBus;
                        busStart_o <= 1'b1;
                        errorQ     <= 1'b0;
                        dispWriteQ <= 1'b0;
                    end else begin
                        state <= idle;
                    end
                end
                waitBus: begin
                    if (busDone_i) begin
                        state <= respond;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && inDisplay) begin
            rdata_o <= '0;
            if (isWrite) begin
                dispAddr_o <= coreReq_i.addr;
                dispData_o <= coreReq_i.wdata;
            end
        end else if (accept) begin
            busReq_o.we    <= isWrite;
            busReq_o.addr  <= coreReq_i.addr;
            busReq_o.wdata <= coreReq_i.wdata;
            busReq_o.sel   <= coreReq_i.byteEn;
        end
        // write completions return zero data
        if (busDone_i) begin
            rdata_o <= busReq_o.we ? '0 : busRdata_i;
        end
    end

endmodule

// File: design/sramWishbone.sv
module sramWishbone import memBusPkg::*; #(
    parameter int SRAM_WORDS  = 256,
    parameter int WAIT_STATES = 2
) (
    input  logic     clk,
    input  logic     rstN_i,
    input  wbMasterT wbM_i,
    output wbSlaveT  wbS_o
);

    localparam int IDX_W  = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;
    localparam int WAIT_W = 3;

    dataT              mem [SRAM_WORDS];
    addrT              wordAddr;
    logic [IDX_W-1:0]  idx;
    logic [WAIT_W-1:0] waitCnt;
    logic              ackQ;
    logic              ackSet;
    dataT              rdataQ;

    // word index from address bits 2 and up, wrapped to the depth
    assign wordAddr = wbM_i.adr >> 2;
    assign idx      = IDX_W'(wordAddr % SRAM_WORDS);

    // ack on the edge where the wait count has run out
    assign ackSet = wbM_i.cyc && wbM_i.stb && !ackQ && (waitCnt == WAIT_W'(WAIT_STATES));

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            waitCnt <= '0;
            ackQ    <= 1'b0;
        end else begin
            ackQ <= ackSet;
            if (ackSet || ackQ || !wbM_i.stb) begin
                waitCnt <= '0;
            end else begin
                waitCnt <= waitCnt + 1'b1;
            end
        end
    end

    // byte-lane writes, lanes without sel keep their old contents
    always_ff @(posedge clk) begin
        if (ackSet && wbM_i.we) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (wbM_i.sel[lane]) begin
                    mem[idx][lane*8 +: 8] <= wbM_i.dat[lane*8 +: 8];
                end
            end
        end
    end

    // read word is presented in the ack cycle
    always_ff @(posedge clk) begin
        if (ackSet && !wbM_i.we) begin
            rdataQ <= mem[idx];
        end
    end

    assign wbS_o.ack = ackQ;
    assign wbS_o.dat = rdataQ;

endmodule

// File: design/wishboneManager.sv
module wishboneManager import memBusPkg::*; (
    input  logic     clk,
    input  logic     rstN_i,
    input  busReqT   busReq_i,
    input  logic     busStart_i,
    output logic     busDone_o,
    output dataT     busRdata_o,
    output wbMasterT wbM_o,
    input  wbSlaveT  wbS_i
);

    typedef enum logic [1:0] {
        idle,
        issue,
        active,
        finish
    } stateE;

    stateE  state;
    busReqT reqQ;
    logic   load;
    logic   inCycle;
    logic   ackSeen;

    // starts only arrive in idle since the core waits for done
    assign load    = busStart_i && (state == idle);
    assign inCycle = (state == issue) || (state == active);
    assign ackSeen = inCycle && wbS_i.ack;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (busStart_i) begin
                        state <= issue;
                    end
                end
                issue: begin
                    // registered slave ack never arrives in the first stb cycle
                    state <= active;
                end
                active: begin
                    if (wbS_i.ack) begin
                        state <= finish;
                    end
                end
                finish: begin
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // one-entry request buffer
    always_ff @(posedge clk) begin
        if (load) begin
            reqQ <= busReq_i;
        end
    end

    // read data is valid together with ack
    always_ff @(posedge clk) begin
        if (ackSeen) begin
            busRdata_o <= wbS_i.dat;
        end
    end

    assign busDone_o = state == finish;

    // cyc and stb rise and fall together
    assign wbM_o.cyc = inCycle;
    assign wbM_o.stb = inCycle;
    // payload comes straight from the buffer
    assign wbM_o.we  = reqQ.we;
    assign wbM_o.adr = reqQ.addr;
    assign wbM_o.dat = reqQ.wdata;
    assign wbM_o.sel = reqQ.sel;

endmodule

// File: tests/memSubsystemTb.sv
module memSubsystemTb import memBusPkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int SRAM_WORDS  = 256;
    localparam int WAIT_STATES = 2;
    localparam int NUM_REQ     = 96;
    // a request takes WAIT_STATES+6 cycles at most, reset and drain add a few
    localparam int WATCHDOG_CYCLES = 16 + NUM_REQ * (WAIT_STATES + 8);

    logic    clk = 1'b0;
    logic    rstN_i;
    coreReqT coreReq_i;
    logic    busy_o;
    logic    done_o;
    dataT    rdata_o;
    logic    accessError_o;
    logic    dispWrite_o;
    addrT    dispAddr_o;
    dataT    dispData_o;

    logic [31:0] rngState;
    dataT        model [int];
    int          written [$];
    int          acceptCount = 0;
    int          doneCount = 0;

    memSubsystemTop #(.SRAM_WORDS(SRAM_WORDS), .WAIT_STATES(WAIT_STATES)) DUT (.*);

    bind memSubsystemTop memSubsystemChecker #(.WAIT_STATES(WAIT_STATES)) busChecker (
        .clk(clk), .rstN_i(rstN_i), .coreReq_i(coreReq_i),
        .busy_i(busy_o), .done_i(done_o), .rdata_i(rdata_o),
        .accessError_i(accessError_o), .dispWrite_i(dispWrite_o),
        .dispAddr_i(dispAddr_o), .dispData_i(dispData_o),
        .busStart_i(busStart), .wbM_i(wbM), .wbS_i(wbS)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("ERROR %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // only lanes with an enable bit take the new byte
    function automatic dataT mergeLanes(dataT oldWord, dataT newWord, byteEnT lanes);
        dataT result;
        result = oldWord;
        for (int b = 0; b < BYTE_LANES; b++) begin
            if (lanes[b]) begin
                result[b*8 +: 8] = newWord[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic coreReqT junkRequest();
        coreReqT r;
        r.access = accessE'(nextRandom() % 3);
        r.addr   = nextRandom();
        r.wdata  = nextRandom();
        r.byteEn = byteEnT'(nextRandom());
        return r;
    endfunction

    // hold edges stay below 4 so the request is idle before busy falls
    task automatic runRequest(input coreReqT req, input int holdCycles,
                              output dataT rdata, output logic err);
        logic busyNow;
        int   waited;
        @(posedge clk);
        coreReq_i <= req;
        busyNow = 1'b1;
        waited = 0;
        while (busyNow) begin
            @(negedge clk);
            busyNow = busy_o;
            @(posedge clk);
            waited++;
            if (busyNow && waited > WAIT_STATES + 8) begin
                abortRun("request was never accepted because busy_o stayed high");
            end
        end
        acceptCount++;
        // keep or scramble the request while the transaction runs
        for (int i = 0; i < holdCycles; i++) begin
            coreReq_i <= (nextRandom() & 1) ? req : junkRequest();
            @(posedge clk);
        end
        coreReq_i <= '0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (!done_o && waited > WAIT_STATES + 8) begin
                abortRun("done_o did not arrive for an accepted request");
            end
        end while (!done_o);
        rdata = rdata_o;
        err = accessError_o;
    endtask

    task automatic sramAccess(input logic isWrite);
        coreReqT req;
        dataT    rd;
        logic    err;
        int      key;
        key = isWrite ? int'(nextRandom() % 32) : written[nextRandom() % written.size()];
        req.access = isWrite ? accessWrite : accessRead;
        // upper bits vary but alias onto the same word
        req.addr   = (nextRandom() & 32'h00FF_0000) | addrT'(key << 2);
        req.wdata  = nextRandom();
        req.byteEn = model.exists(key) ? byteEnT'(nextRandom()) : 4'hF;
        runRequest(req, int'(nextRandom() % 4), rd, err);
        checkValue("accessError_o", 32'(err), 32'h0);
        key = int'((req.addr >> 2) % SRAM_WORDS);
        if (!isWrite) begin
            checkValue("rdata_o", rd, model[key]);
        end else if (model.exists(key)) begin
            model[key] = mergeLanes(model[key], req.wdata, req.byteEn);
        end else begin
            model[key] = req.wdata;
            written.push_back(key);
        end
    endtask

    task automatic displayAccess(input logic isWrite);
        coreReqT req;
        dataT    rd;
        logic    err;
        req.access = isWrite ? accessWrite : accessRead;
        req.addr   = DISPLAY_BASE | (nextRandom() & 32'h0000_FFFC);
        req.wdata  = nextRandom();
        req.byteEn = byteEnT'(nextRandom());
        runRequest(req, 0, rd, err);
        checkValue("accessError_o", 32'(err), isWrite ? 32'h0 : 32'h1);
        if (!isWrite) begin
            checkValue("rdata_o", rd, 32'h0);
        end
    endtask

    always @(negedge clk) begin
        if (rstN_i && done_o) begin
            doneCount++;
        end
        if (DUT.busChecker.failCount != 0) begin
            abortRun("a bound assertion failed, see the error above");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abortRun("watchdog expired before all requests completed");
    end

    initial begin
        int unsigned op;
        rstN_i = 1'b0;
        coreReq_i = '0;
        rngState = 32'h1d6b25ea;
        repeat (10) @(posedge clk);
        rstN_i <= 1'b1;
        for (int n = 0; n < NUM_REQ; n++) begin
            op = nextRandom() % 8;
            // fill some words first, then read them back, then mix
            if (n < 16) begin
                op = 0;
            end else if (n < 32) begin
                op = 4;
            end
            case (op)
                0, 1, 2: sramAccess(1'b1);
                3, 4, 5: sramAccess(1'b0);
                6:       displayAccess(1'b1);
                default: displayAccess(1'b0);
            endcase
        end
        repeat (3) @(posedge clk);
        if (doneCount == acceptCount) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abortRun($sformatf("ERROR doneCount: got %h expected %h", doneCount, acceptCount));
        end
    end

endmodule

// File: tests/memSubsystem_checker.sv
module memSubsystemChecker import memBusPkg::*; #(
    parameter int WAIT_STATES = 2
) (
    input logic     clk,
    input logic     rstN_i,
    input coreReqT  coreReq_i,
    input logic     busy_i,
    input logic     done_i,
    input dataT     rdata_i,
    input logic     accessError_i,
    input logic     dispWrite_i,
    input addrT     dispAddr_i,
    input dataT     dispData_i,
    input logic     busStart_i,
    input wbMasterT wbM_i,
    input wbSlaveT  wbS_i
);

    int unsigned failCount = 0;
    logic        accept;
    logic        inDisplay;

    // a read or write is taken whenever busy is low
    assign accept    = (coreReq_i.access inside {accessWrite, accessRead}) && !busy_i;
    assign inDisplay = (coreReq_i.addr & DISPLAY_MASK) == DISPLAY_BASE;

    // busy covers every cycle between acceptance and the done pulse
    sramLatency: assert property (@(posedge clk) disable iff (!rstN_i)
        accept && !inDisplay |=> (busy_i && !done_i) [*(WAIT_STATES + 4)] ##1 (done_i && !busy_i))
    else begin
        $error("SRAM access did not complete WAIT_STATES+5 cycles after acceptance");
        failCount++;
    end

    dispWriteResp: assert property (@(posedge clk) disable iff (!rstN_i)
        accept && inDisplay && coreReq_i.access == accessWrite |=>
            dispWrite_i && done_i && !busy_i && !accessError_i && !busStart_i
            && dispAddr_i == $past(coreReq_i.addr) && dispData_i == $past(coreReq_i.wdata))
    else begin
        $error("display write did not pulse with its address and data one cycle later");
        failCount++;
    end

    dispReadResp: assert property (@(posedge clk) disable iff (!rstN_i)
        accept && inDisplay && coreReq_i.access == accessRead |=>
            accessError_i && done_i && !dispWrite_i && !busy_i && !busStart_i && rdata_i == '0)
    else begin
        $error("display read was not answered with an access error and zero data");
        failCount++;
    end

    ackWithStb: assert property (@(posedge clk) disable iff (!rstN_i)
        wbS_i.ack |-> wbM_i.cyc && wbM_i.stb)
    else begin
        $error("ack seen while stb was low");
        failCount++;
    end

    // one ack per cycle, and the manager drops stb right after it
    ackSingle: assert property (@(posedge clk) disable iff (!rstN_i)
        wbS_i.ack |=> !wbS_i.ack && !wbM_i.stb)
    else begin
        $error("ack lasted more than one cycle or stb stayed up after it");
        failCount++;
    end

    busStable: assert property (@(posedge clk) disable iff (!rstN_i)
        wbM_i.stb && !wbS_i.ack |=> wbM_i.stb && $stable(wbM_i.adr) && $stable(wbM_i.dat)
            && $stable(wbM_i.we) && $stable(wbM_i.sel))
    else begin
        $error("bus request changed while stb waited for ack");
        failCount++;
    end

    resetValues: assert property (@(posedge clk)
        $rose(rstN_i) |-> !busy_i && !done_i && !dispWrite_i && !accessError_i
            && !wbM_i.cyc && !wbS_i.ack)
    else begin
        $error("outputs not low in the first cycle after reset");
        failCount++;
    end

endmodule
